// File: build.f
+incdir+rtl
rtl/chk_cfg_pkg.sv
rtl/chk_part_pkg.sv
rtl/chk_lfsr.sv
rtl/chk_countdown.sv
rtl/chk_sched.sv
rtl/chk_timer_top.sv
verification/chk_timer_checker.sv
verification/tb_chk_timer.sv

// File: rtl/chk_cfg_pkg.sv
// Configuration and entropy source types that enter the check timer from outside
`include "chk_timer_macros.svh"

package chk_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Software configuration
  ////////////////////////////////////////////////////////////////////////////

  // Quasi-static, written by software before the timer is enabled
  // Zero mask disables that periodic timer, zero timeout disables the timeout
  typedef struct packed {
    logic        timer_en;
    logic [31:0] timeout;
    logic [31:0] integ_msk;
    logic [31:0] cnsty_msk;
  } chk_cfg_t;

  ////////////////////////////////////////////////////////////////////////////
  // Entropy source response
  ////////////////////////////////////////////////////////////////////////////

  // Data is only valid in the cycle where ack is high
  typedef struct packed {
    logic                   ack;
    logic [`CHK_LFSR_W-1:0] data;
  } edn_rsp_t;

endpackage

// File: rtl/chk_countdown.sv
// Loadable down-counter with pause and zero flag for the check timers
`timescale 1ns/10ps

module chk_countdown (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        load_i,
  input  logic [31:0] load_val_i,
  input  logic        pause_i,
  output logic        zero_o
);

  logic [31:0] cnt_d, cnt_q;

  assign zero_o = (cnt_q == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Counter
  ////////////////////////////////////////////////////////////////////////////

  // Load wins over counting and the count stops at zero
  always_comb begin
    cnt_d = cnt_q;
    if (load_i) begin
      cnt_d = load_val_i;
    end else if (!zero_o && !pause_i) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  // Starts expired so an enabled timer fires right away
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // A wrap would show as a rise of the count without a load
  no_wrap_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !load_i |=> (cnt_q <= $past(cnt_q)));

endmodule

// File: rtl/chk_lfsr.sv
// Galois LFSR with draw counter, entropy reseed request and reseed merge
`timescale 1ns/10ps
`include "chk_timer_macros.svh"

module chk_lfsr
  import chk_cfg_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   draw_i,
  input  edn_rsp_t               edn_rsp_i,
  output logic                   edn_req_o,
  output logic [`CHK_LFSR_W-1:0] state_o
);

  localparam int CntW = $clog2(`CHK_RESEED_THRESH + 1);

  logic [`CHK_LFSR_W-1:0] state_d, state_q;
  logic [`CHK_LFSR_W-1:0] stepped, merged;
  logic [CntW-1:0]        cnt_d, cnt_q;
  logic                   reseed;

  ////////////////////////////////////////////////////////////////////////////
  // Draw counter and reseed request
  ////////////////////////////////////////////////////////////////////////////

  // Request stays up until the entropy source answers
  assign edn_req_o = (cnt_q >= CntW'(`CHK_RESEED_THRESH));
  assign reseed    = edn_req_o & edn_rsp_i.ack;

  // Draws during an outstanding request are not counted
  always_comb begin
    cnt_d = cnt_q;
    if (reseed) begin
      cnt_d = '0;
    end else if (draw_i && !edn_req_o) begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State update
  ////////////////////////////////////////////////////////////////////////////

  // Right shift, taps folded in when the bit shifted out is set
  assign stepped = !draw_i    ? state_q :
                   state_q[0] ? ((state_q >> 1) ^ `CHK_LFSR_TAPS) :
                                (state_q >> 1);

  assign merged = stepped ^ edn_rsp_i.data;

  // An all-zero merge would lock up, fall back to the seed
  always_comb begin
    state_d = stepped;
    if (reseed) begin
      state_d = (merged == '0) ? `CHK_LFSR_SEED : merged;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= `CHK_LFSR_SEED;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  assign state_o = state_q;

  // Zero state would stall all periodic draws
  state_nonzero_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q != '0);

endmodule

// File: rtl/chk_part_pkg.sv
// Partition request and ack vectors and the sparse scheduler state encoding
`include "chk_timer_macros.svh"

package chk_part_pkg;

  // One bit per partition
  typedef logic [`CHK_NUM_PART-1:0] part_vec_t;

  // Same layout for requests towards and acks from the partitions
  typedef struct packed {
    part_vec_t integ;
    part_vec_t cnsty;
  } chk_req_t;

  ////////////////////////////////////////////////////////////////////////////
  // Scheduler states
  ////////////////////////////////////////////////////////////////////////////

  // Sparse encoding, pairwise Hamming distance of at least four
  typedef enum logic [8:0] {
    ResetSt     = 9'b101001100,
    IdleSt      = 9'b010110100,
    IntegWaitSt = 9'b100111011,
    CnstyWaitSt = 9'b011000011,
    ErrorSt     = 9'b110000101
  } sched_state_e;

endpackage

// File: rtl/chk_sched.sv
// Check scheduler FSM: triggers, periodic timers, partition requests, timeout and error
`timescale 1ns/10ps

module chk_sched
  import chk_cfg_pkg::*;
  import chk_part_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  chk_cfg_t    cfg_i,
  input  logic        integ_trig_i,
  input  logic        cnsty_trig_i,
  input  logic        prog_busy_i,
  input  logic        escalate_i,
  input  chk_req_t    chk_ack_i,
  input  logic        integ_zero_i,
  input  logic        cnsty_zero_i,
  input  logic [31:0] lfsr_state_i,
  output logic        draw_o,
  output logic        integ_load_o,
  output logic        cnsty_load_o,
  output logic        cnsty_pause_o,
  output logic [31:0] load_val_o,
  output chk_req_t    chk_req_o,
  output logic        chk_pending_o,
  output logic        chk_timeout_o,
  output logic        fsm_err_o
);

  sched_state_e state_d, state_q;
  chk_req_t     req_d, req_q;
  logic         integ_trig_d, integ_trig_q, cnsty_trig_d, cnsty_trig_q;
  logic         clr_integ_trig, clr_cnsty_trig, set_integ, set_cnsty;
  logic         timeout_d, timeout_q, timeout_off, integ_off, cnsty_off;

  assign timeout_off = (cfg_i.timeout == '0);
  assign integ_off   = (cfg_i.integ_msk == '0);
  assign cnsty_off   = (cfg_i.cnsty_msk == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Trigger latches and request vectors
  ////////////////////////////////////////////////////////////////////////////

  // One-off strobes are held until the FSM takes them
  assign integ_trig_d = (integ_trig_q & ~clr_integ_trig) | integ_trig_i;
  assign cnsty_trig_d = (cnsty_trig_q & ~clr_cnsty_trig) | cnsty_trig_i;

  // All bits set together, each cleared by its own ack
  assign req_d.integ = set_integ ? '1 : (req_q.integ & ~chk_ack_i.integ);
  assign req_d.cnsty = set_cnsty ? '1 : (req_q.cnsty & ~chk_ack_i.cnsty);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    timeout_d      = timeout_q;
    draw_o         = 1'b0;
    integ_load_o   = 1'b0;
    cnsty_load_o   = 1'b0;
    cnsty_pause_o  = 1'b0;
    load_val_o     = cfg_i.timeout;
    set_integ      = 1'b0;
    set_cnsty      = 1'b0;
    clr_integ_trig = 1'b0;
    clr_cnsty_trig = 1'b0;
    chk_pending_o  = integ_trig_q | cnsty_trig_q;
    fsm_err_o      = 1'b0;
    case (state_q)
      // Held here until software enables the timer, first draw on exit
      ResetSt: begin
        if (cfg_i.timer_en) begin
          state_d = IdleSt;
          draw_o  = 1'b1;
        end
      end
      // Integrity first when both are due; entry loads the timeout
      IdleSt: begin
        if ((!integ_off && integ_zero_i) || integ_trig_q) begin
          state_d        = IntegWaitSt;
          integ_load_o   = 1'b1;
          set_integ      = 1'b1;
          clr_integ_trig = integ_trig_q;
        end else if ((!cnsty_off && cnsty_zero_i) || cnsty_trig_q) begin
          state_d        = CnstyWaitSt;
          cnsty_load_o   = 1'b1;
          set_cnsty      = 1'b1;
          clr_cnsty_trig = cnsty_trig_q;
        end
      end
      IntegWaitSt: begin
        chk_pending_o = 1'b1;
        if (!timeout_off && integ_zero_i) begin
          state_d   = ErrorSt;
          timeout_d = 1'b1;
        end else if (req_q.integ == '0) begin
          // Done, draw the next wait period
          state_d      = IdleSt;
          draw_o       = 1'b1;
          integ_load_o = 1'b1;
          load_val_o   = lfsr_state_i & cfg_i.integ_msk;
        end
      end
      CnstyWaitSt: begin
        chk_pending_o = 1'b1;
        // Programming competes for the array, so the timeout holds
        cnsty_pause_o = prog_busy_i;
        if (!timeout_off && cnsty_zero_i) begin
          state_d   = ErrorSt;
          timeout_d = 1'b1;
        end else if (req_q.cnsty == '0) begin
          state_d      = IdleSt;
          draw_o       = 1'b1;
          cnsty_load_o = 1'b1;
          load_val_o   = lfsr_state_i & cfg_i.cnsty_msk;
        end
      end
      // Terminal, pending triggers are dropped
      ErrorSt: begin
        clr_integ_trig = 1'b1;
        clr_cnsty_trig = 1'b1;
        chk_pending_o  = 1'b0;
        fsm_err_o      = !timeout_q;
      end
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything
    if (escalate_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ResetSt;
      req_q        <= '0;
      timeout_q    <= 1'b0;
      integ_trig_q <= 1'b0;
      cnsty_trig_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      req_q        <= req_d;
      timeout_q    <= timeout_d;
      integ_trig_q <= integ_trig_d;
      cnsty_trig_q <= cnsty_trig_d;
    end
  end

  assign chk_req_o     = req_q;
  assign chk_timeout_o = timeout_q;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Idle is only reached once every partition has answered
  idle_no_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == IdleSt) |-> (req_q == '0));

  state_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {ResetSt, IdleSt, IntegWaitSt, CnstyWaitSt, ErrorSt});

endmodule

// File: rtl/chk_timer_macros.svh
// Check timer build constants: partition count, LFSR width, seed, taps, reseed threshold
`ifndef CHK_TIMER_MACROS_SVH
`define CHK_TIMER_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Partitions
////////////////////////////////////////////////////////////////////////////

// Number of partitions that take part in every check
`define CHK_NUM_PART 4

////////////////////////////////////////////////////////////////////////////
// Wait period LFSR
////////////////////////////////////////////////////////////////////////////

// State width, also the width of the entropy word
`define CHK_LFSR_W 32
// Reset state, must be nonzero
`define CHK_LFSR_SEED 32'h5A3C_96E1
// Galois feedback mask for a right-shifting register, maximal length
`define CHK_LFSR_TAPS 32'hB4BC_D35C
// Draws allowed before fresh entropy is requested
`define CHK_RESEED_THRESH 8

`endif

// File: rtl/chk_timer_top.sv
// Check timer top level: LFSR, integrity and consistency countdowns, scheduler
`timescale 1ns/10ps
`include "chk_timer_macros.svh"

module chk_timer_top
  import chk_cfg_pkg::*;
  import chk_part_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  chk_cfg_t cfg_i,
  input  logic     integ_trig_i,
  input  logic     cnsty_trig_i,
  input  logic     prog_busy_i,
  input  logic     escalate_i,
  input  edn_rsp_t edn_rsp_i,
  input  chk_req_t chk_ack_i,
  output chk_req_t chk_req_o,
  output logic     edn_req_o,
  output logic     chk_pending_o,
  output logic     chk_timeout_o,
  output logic     fsm_err_o
);

  logic [`CHK_LFSR_W-1:0] lfsr_state;
  logic [31:0]            load_val;
  logic                   draw, integ_load, cnsty_load, cnsty_pause;
  logic                   integ_zero, cnsty_zero;

  ////////////////////////////////////////////////////////////////////////////
  // Wait period source and countdowns
  ////////////////////////////////////////////////////////////////////////////

  chk_lfsr u_lfsr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .draw_i    (draw),
    .edn_rsp_i (edn_rsp_i),
    .edn_req_o (edn_req_o),
    .state_o   (lfsr_state)
  );

  // Integrity timeout never pauses
  chk_countdown u_integ_cnt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (integ_load),
    .load_val_i (load_val),
    .pause_i    (1'b0),
    .zero_o     (integ_zero)
  );

  chk_countdown u_cnsty_cnt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (cnsty_load),
    .load_val_i (load_val),
    .pause_i    (cnsty_pause),
    .zero_o     (cnsty_zero)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Scheduler
  ////////////////////////////////////////////////////////////////////////////

  chk_sched u_sched (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_i         (cfg_i),
    .integ_trig_i  (integ_trig_i),
    .cnsty_trig_i  (cnsty_trig_i),
    .prog_busy_i   (prog_busy_i),
    .escalate_i    (escalate_i),
    .chk_ack_i     (chk_ack_i),
    .integ_zero_i  (integ_zero),
    .cnsty_zero_i  (cnsty_zero),
    .lfsr_state_i  (lfsr_state),
    .draw_o        (draw),
    .integ_load_o  (integ_load),
    .cnsty_load_o  (cnsty_load),
    .cnsty_pause_o (cnsty_pause),
    .load_val_o    (load_val),
    .chk_req_o     (chk_req_o),
    .chk_pending_o (chk_pending_o),
    .chk_timeout_o (chk_timeout_o),
    .fsm_err_o     (fsm_err_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile the check timer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_chk_timer -Mdir obj_dir -o sim_chk_timer
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_chk_timer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi

// File: verification/chk_timer_checker.sv
// Result checker: DUT output sampling, value and range compares, per-test result lines
`timescale 1ns/10ps

module chk_timer_checker
  import chk_part_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  chk_req_t chk_req_i,
  input  logic     edn_req_i,
  input  logic     pending_i,
  input  logic     timeout_i,
  input  logic     fsm_err_i
);

  // Requests, edn request, pending, timeout, error from msb to lsb
  logic [11:0] obs;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  bit          test_bad = 1'b0;
  bit          err_seen = 1'b0;

  assign obs = {chk_req_i, edn_req_i, pending_i, timeout_i, fsm_err_i};

  ////////////////////////////////////////////////////////////////////////////
  // Error flag must hold until reset
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      err_seen = 1'b0;
    end else if (fsm_err_i) begin
      err_seen = 1'b1;
    end else if (err_seen) begin
      $display("fsm_err_o fell without a reset");
      test_bad = 1'b1;
      err_seen = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      test_bad = 1'b1;
    end
  endtask

  task automatic check_range(input string name, input int lo, input int hi, input int act);
    if (act < lo || act > hi) begin
      $display("ERR %s expected %0d..%0d actual %0d", name, lo, hi, act);
      test_bad = 1'b1;
    end
  endtask

  task automatic fail_msg(input string name, input string what);
    $display("%s: %s", name, what);
    test_bad = 1'b1;
  endtask

  task automatic end_test(input string name);
    if (test_bad) begin
      fail_cnt++;
      $display("FAIL %s", name);
    end else begin
      pass_cnt++;
      $display("PASS %s", name);
    end
    test_bad = 1'b0;
  endtask

  task automatic report();
    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
  endtask

endmodule

// File: verification/chk_timer_stim.txt
# name kind p1 p2 budget expected, numbers in hex
# p1/p2: idle cycles, timeout and busy cycles, or number of checks
reset_idle idle 14 0 14 000
integ_trig trig 0 0 50 f04
cnsty_timeout tmo 14 6 3c 0f2
integ_periodic per 6 0 12c 12
edn_reseed edn 0 0 190 7
escalate esc 0 0 1e 001

// File: verification/tb_chk_timer.sv
// Testbench top with clock, reset, stim file reader, partition ack model and watchdog
`timescale 1ns/10ps

module tb_chk_timer
  import chk_cfg_pkg::*;
  import chk_part_pkg::*;
();

  logic        clk_i, rst_ni;
  chk_cfg_t    cfg;
  logic        integ_trig, cnsty_trig, prog_busy, escalate;
  edn_rsp_t    edn_rsp;
  chk_req_t    chk_ack, chk_req;
  logic        edn_req, pending, timeout, fsm_err;
  logic [7:0]  req_bits;
  logic [7:0]  ack_bits = '0;
  logic [2:0]  dly [8];
  logic [31:0] rng = 32'd9;
  bit          ack_en, stim_ready;
  int          cyc = 0;
  int          ack_idx, n_tests, total_cycles;
  string       names [16];
  string       kinds [16];
  int          p1 [16];
  int          p2 [16];
  int          budget [16];
  int          expv [16];

  chk_timer_top dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_i         (cfg),
    .integ_trig_i  (integ_trig),
    .cnsty_trig_i  (cnsty_trig),
    .prog_busy_i   (prog_busy),
    .escalate_i    (escalate),
    .edn_rsp_i     (edn_rsp),
    .chk_ack_i     (chk_ack),
    .chk_req_o     (chk_req),
    .edn_req_o     (edn_req),
    .chk_pending_o (pending),
    .chk_timeout_o (timeout),
    .fsm_err_o     (fsm_err)
  );

  chk_timer_checker u_chk (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .chk_req_i (chk_req),
    .edn_req_i (edn_req),
    .pending_i (pending),
    .timeout_i (timeout),
    .fsm_err_i (fsm_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Partition model where each bit acks after its own random delay
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [2:0] rand_delay();
    logic [2:0] d;
    d = '0;
    // Galois step per bit taken
    repeat (3) begin
      rng = rng[0] ? ((rng >> 1) ^ 32'hA300_0000) : (rng >> 1);
      d   = {d[1:0], rng[0]};
    end
    return d;
  endfunction

  assign req_bits = chk_req;
  assign chk_ack  = ack_bits;

  always @(posedge clk_i) begin
    #10;
    for (ack_idx = 0; ack_idx < 8; ack_idx++) begin
      if (!ack_en || !req_bits[ack_idx]) begin
        ack_bits[ack_idx] = 1'b0;
        dly[ack_idx]      = rand_delay();
      end else if (dly[ack_idx] == '0) begin
        ack_bits[ack_idx] = 1'b1;
      end else begin
        dly[ack_idx] = dly[ack_idx] - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_dut(input logic en, input logic [31:0] tmo, input logic [31:0] imsk,
                           input logic [31:0] cmsk);
    @(posedge clk_i);
    #10;
    rst_ni        = 1'b0;
    ack_en        = 1'b0;
    cfg.timer_en  = en;
    cfg.timeout   = tmo;
    cfg.integ_msk = imsk;
    cfg.cnsty_msk = cmsk;
    integ_trig    = 1'b0;
    cnsty_trig    = 1'b0;
    prog_busy     = 1'b0;
    escalate      = 1'b0;
    edn_rsp       = '0;
    repeat (5) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
  endtask

  // One-cycle strobe on integrity (0), consistency (1) or escalation (other)
  task automatic strobe(input int which);
    for (int v = 1; v >= 0; v--) begin
      @(posedge clk_i);
      #10;
      case (which)
        0:       integ_trig = v[0];
        1:       cnsty_trig = v[0];
        default: escalate   = v[0];
      endcase
    end
  endtask

  task automatic wait_obs(input logic [11:0] mask, input logic [11:0] val, input int max,
                          output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < max) begin
      @(negedge clk_i);
      n++;
      if ((u_chk.obs & mask) == val) ok = 1'b1;
    end
  endtask

  // Counts completed integrity checks and the longest completion-to-start gap
  task automatic count_checks(input int n, input int max, input bit stop_edn, output int done,
                              output int max_gap, output bit cn_seen);
    logic [7:0] prev, cur;
    int         t_done, k;
    prev    = '0;
    done    = 0;
    max_gap = 0;
    cn_seen = 1'b0;
    t_done  = -1;
    k       = 0;
    while (done < n && k < max && !(stop_edn && u_chk.obs[3])) begin
      @(negedge clk_i);
      k++;
      cur = u_chk.obs[11:4];
      if (cur[3:0] != '0) cn_seen = 1'b1;
      if (prev[7:4] != '0 && cur[7:4] == '0) begin
        done++;
        t_done = cyc;
      end
      if (prev[7:4] == '0 && cur[7:4] != '0 && t_done >= 0 && cyc - t_done > max_gap) begin
        max_gap = cyc - t_done;
      end
      prev = cur;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  // Both masks armed, so only timer_en keeps the scheduler quiet
  task automatic quiet_after_reset(input string name, input int n, input int exp);
    logic [11:0] acc;
    acc = '0;
    reset_dut(1'b0, '0, 32'd15, 32'd15);
    repeat (n) begin
      @(negedge clk_i);
      acc |= u_chk.obs;
    end
    u_chk.check_val(name, exp, acc);
  endtask

  task automatic integ_trigger_handshake(input string name, input int max, input int exp);
    bit ok;
    reset_dut(1'b1, '0, '0, '0);
    ack_en = 1'b1;
    repeat (2) @(posedge clk_i);
    strobe(0);
    // Requests are due on the second edge after the strobe
    @(posedge clk_i);
    @(negedge clk_i);
    u_chk.check_val(name, exp, u_chk.obs);
    wait_obs(12'hfff, 12'h000, max, ok);
    if (!ok) u_chk.fail_msg(name, "integrity requests or pending never cleared");
  endtask

  task automatic cnsty_busy_timeout(input string name, input int t, input int p, input int max,
                                    input int exp);
    int t_req;
    bit ok;
    reset_dut(1'b1, t, '0, '0);
    repeat (2) @(posedge clk_i);
    strobe(1);
    @(posedge clk_i);
    #10;
    prog_busy = 1'b1;
    @(negedge clk_i);
    t_req = cyc;
    if (u_chk.obs[11:4] != 8'h0f) u_chk.fail_msg(name, "consistency requests did not rise");
    // Busy covers exactly p edges of the wait state
    repeat (p) @(posedge clk_i);
    #10;
    prog_busy = 1'b0;
    wait_obs(12'h002, 12'h002, max, ok);
    if (!ok) begin
      u_chk.fail_msg(name, "timeout never raised");
    end else begin
      u_chk.check_range(name, t + p + 1, t + p + 3, cyc - t_req);
      u_chk.check_val(name, exp, u_chk.obs);
    end
  endtask

  task automatic periodic_integ_checks(input string name, input int n, input int max,
                                       input int exp);
    int done, gap;
    bit cn;
    reset_dut(1'b1, '0, 32'd15, '0);
    ack_en = 1'b1;
    count_checks(n, max, 1'b0, done, gap, cn);
    if (done < n) u_chk.fail_msg(name, "fewer periodic checks than expected");
    u_chk.check_range(name, 0, exp, gap);
    u_chk.check_val(name, 0, cn);
  endtask

  task automatic entropy_reseed(input string name, input int max, input int exp);
    int done, gap;
    bit cn;
    reset_dut(1'b1, '0, 32'd15, '0);
    ack_en = 1'b1;
    count_checks(1000, max, 1'b1, done, gap, cn);
    if (!u_chk.obs[3]) begin
      u_chk.fail_msg(name, "no entropy request after periodic draws");
    end else begin
      u_chk.check_val(name, exp, done);
      @(posedge clk_i);
      #10;
      edn_rsp.ack  = 1'b1;
      edn_rsp.data = 32'hC3A5_0F96;
      @(posedge clk_i);
      #10;
      edn_rsp = '0;
      @(negedge clk_i);
      if (u_chk.obs[3]) u_chk.fail_msg(name, "entropy request stayed high after ack");
      count_checks(2, max, 1'b0, done, gap, cn);
      if (done < 2) u_chk.fail_msg(name, "periodic checks stopped after reseed");
    end
  endtask

  task automatic escalation_lockout(input string name, input int exp);
    logic [11:0] acc;
    reset_dut(1'b1, '0, '0, '0);
    ack_en = 1'b1;
    repeat (2) @(posedge clk_i);
    strobe(2);
    @(negedge clk_i);
    if (!u_chk.obs[0]) u_chk.fail_msg(name, "fsm_err_o did not rise on escalation");
    strobe(0);
    acc = '0;
    repeat (10) begin
      @(negedge clk_i);
      acc |= u_chk.obs;
    end
    u_chk.check_val(name, exp, acc);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int    fd, rc, a, b, c, d;
    string line, nm, kd;
    rst_ni     = 1'b0;
    cfg        = '0;
    integ_trig = 1'b0;
    cnsty_trig = 1'b0;
    prog_busy  = 1'b0;
    escalate   = 1'b0;
    edn_rsp    = '0;
    ack_en     = 1'b0;
    n_tests    = 0;
    total_cycles = 50;
    fd = $fopen("verification/chk_timer_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file verification/chk_timer_stim.txt");
      $display("Test failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 1 && line[0] != "#" && n_tests < 16) begin
          rc = $sscanf(line, "%s %s %h %h %h %h", nm, kd, a, b, c, d);
          if (rc == 6) begin
            names[n_tests]  = nm;
            kinds[n_tests]  = kd;
            p1[n_tests]     = a;
            p2[n_tests]     = b;
            budget[n_tests] = c;
            expv[n_tests]   = d;
            total_cycles += c + 10;
            n_tests++;
          end
        end
      end
      $fclose(fd);
      stim_ready = 1'b1;
      for (int i = 0; i < n_tests; i++) begin
        case (kinds[i])
          "idle":  quiet_after_reset(names[i], p1[i], expv[i]);
          "trig":  integ_trigger_handshake(names[i], budget[i], expv[i]);
          "tmo":   cnsty_busy_timeout(names[i], p1[i], p2[i], budget[i], expv[i]);
          "per":   periodic_integ_checks(names[i], p1[i], budget[i], expv[i]);
          "edn":   entropy_reseed(names[i], budget[i], expv[i]);
          "esc":   escalation_lockout(names[i], expv[i]);
          default: u_chk.fail_msg(names[i], "unknown test kind in stimulus file");
        endcase
        u_chk.end_test(names[i]);
      end
      u_chk.report();
      if (u_chk.fail_cnt == 0 && n_tests > 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  initial begin
    wait (stim_ready);
    #(total_cycles * 100);
    $display("Watchdog expired after %0d cycles, a test did not finish", total_cycles);
    $display("Test failed");
    $finish;
  end

endmodule
